// ==== filelist.f ====
+incdir+.
spi_pkg.sv
spi_byte_fifo.sv
spi_brg.sv
spi_regs.sv
spi_frame_ctrl.sv
spi_master_top.sv
tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - include_dirs:
      - .
    files:
      - spi_pkg.sv
      - spi_byte_fifo.sv
      - spi_brg.sv
      - spi_regs.sv
      - spi_frame_ctrl.sv
      - spi_master_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_spi_master.sv

// ==== tb_spi_master.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "spi_params.svh"

module tb_spi_master;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_PM       = 4;
    localparam int MAX_CHARS    = 2;
    // worst frame, both select delays at their 4-bit maximum
    localparam int FRAME_CLKS   = (MAX_PM + 1) * (16 * MAX_CHARS + 2 * (15 + 15)) + 16;
    localparam int POLL_LIMIT   = FRAME_CLKS / 3 + 8;
    localparam int N_FRAMES     = 8;
    localparam int STALL_CLKS   = 100;
    localparam int REG_CLKS     = 800;
    localparam int WATCHDOG_CLKS = RESET_CYCLES + N_FRAMES * (FRAME_CLKS + 32) +
                                   STALL_CLKS + 64 + REG_CLKS;

    logic                S_SYSCLK;
    logic                S_RESETN;
    spi_pkg::reg_wr_t    reg_wr;
    logic [7:0]          araddr;
    logic                rden;
    logic                miso;
    wire  [31:0]         rdata;
    wire                 irq;
    wire                 sck;
    wire                 mosi;
    wire  [`SPI_NCS-1:0] sel;
    wire                 sel_any;

    integer seed = 36269;
    int     errors;
    string  cur_test;

    // external slave model state
    logic       slave_en;
    logic       slave_cpol;
    logic       slave_cpha;
    logic [7:0] slave_tx_sr;
    logic [7:0] slave_rx_sr;
    int         slave_bits;
    int         slave_edges;
    logic [7:0] slave_out_q[$];
    logic [7:0] slave_seen_q[$];

    // select and idle SCK monitor
    logic                mon_en;
    logic                mon_cpol;
    logic                mon_seen;
    logic [`SPI_NCS-1:0] mon_sel_exp;

    spi_master_top dut0 (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_reg_wr(reg_wr), .i_araddr(araddr), .i_reg_rden(rden), .i_spi_miso(miso),
        .o_rdata(rdata), .o_interrupt(irq),
        .o_spi_sck(sck), .o_spi_mosi(mosi), .o_spi_sel(sel)
    );

    assign sel_any = (sel != '1);

    initial begin
        S_SYSCLK = 1'b0;
        forever #(CLK_HALF) S_SYSCLK = ~S_SYSCLK;
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("CHECK FAILED %s: %s expected %h, actual %h", cur_test, what, exp, act);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error in %s: %s", cur_test, what);
    endtask

    task automatic drive_miso_bit();
        // a new byte starts once the previous one is complete
        if (slave_bits == 0) begin
            slave_tx_sr = (slave_out_q.size() > 0) ? slave_out_q.pop_front() : 8'h00;
        end
        miso <= slave_tx_sr[7];
        slave_tx_sr = {slave_tx_sr[6:0], 1'b0};
    endtask

    task automatic sample_mosi();
        slave_rx_sr = {slave_rx_sr[6:0], mosi};
        slave_bits  = slave_bits + 1;
        if (slave_bits == 8) begin
            slave_seen_q.push_back(slave_rx_sr);
            slave_bits = 0;
        end
    endtask

    always @(posedge sel_any) begin
        slave_bits  = 0;
        slave_edges = 0;
        // with CPHA 0 the first bit must be on MISO before the first edge
        if (slave_en && !slave_cpha) begin
            drive_miso_bit();
        end
    end

    always @(sck) begin
        if (slave_en && sel_any) begin
            slave_edges = slave_edges + 1;
            if ((sck != slave_cpol) ^ slave_cpha) begin
                sample_mosi();
            end else begin
                drive_miso_bit();
            end
        end
    end

    always @(negedge S_SYSCLK) begin
        if (mon_en) begin
            if (sel == '1) begin
                if (sck !== mon_cpol) begin
                    report_mismatch("idle SCK", mon_cpol, sck);
                end
            end else begin
                mon_seen = 1'b1;
                if (sel !== mon_sel_exp) begin
                    report_mismatch("select lines", mon_sel_exp, sel);
                end
            end
        end
    end

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        spi_pkg::reg_wr_t wr;
        wr        = '0;
        wr.wen    = 1'b1;
        wr.awaddr = addr;
        wr.wdata  = data;
        wr.wstrb  = 4'hF;
        @(posedge S_SYSCLK);
        reg_wr <= wr;
        @(posedge S_SYSCLK);
        reg_wr <= '0;
    endtask

    // the extra clock lets an SPIRF pop land before the next read
    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge S_SYSCLK);
        araddr <= addr;
        rden   <= 1'b1;
        @(negedge S_SYSCLK);
        data = rdata;
        @(posedge S_SYSCLK);
        rden <= 1'b0;
        @(posedge S_SYSCLK);
    endtask

    task automatic set_mode(input logic en, input logic loop);
        spi_pkg::spmode_t sm;
        sm      = '0;
        sm.en   = en;
        sm.loop = loop;
        write_reg(`SPI_ADDR_SPMODE, sm);
    endtask

    task automatic push_byte(input logic [7:0] b);
        write_reg(`SPI_ADDR_SPITF, {24'h0, b});
    endtask

    task automatic start_frame(input logic [1:0] cs, input logic [15:0] len);
        spi_pkg::spcom_t sc;
        sc         = '0;
        sc.cs      = cs;
        sc.tranlen = len;
        write_reg(`SPI_ADDR_SPCOM, sc);
    endtask

    task automatic clear_done();
        write_reg(`SPI_ADDR_SPIE, 32'h1);
    endtask

    task automatic wait_done();
        spi_pkg::spie_t ie;
        logic [31:0]    v;
        int             polls;
        ie    = '0;
        polls = 0;
        while (!ie.don && polls < POLL_LIMIT) begin
            read_reg(`SPI_ADDR_SPIE, v);
            ie = v;
            polls++;
        end
        if (!ie.don) begin
            report_problem("the frame done flag never came up");
        end
    endtask

    task automatic wait_select(input int idx);
        int cycles;
        cycles = 0;
        @(negedge S_SYSCLK);
        while (sel[idx] !== 1'b0 && cycles < 64) begin
            @(negedge S_SYSCLK);
            cycles++;
        end
        if (sel[idx] !== 1'b0) begin
            report_problem("the select line never went active");
        end
    endtask

    task automatic check_rx(input logic [7:0] exp, input string what);
        logic [31:0] v;
        read_reg(`SPI_ADDR_SPIRF, v);
        if (v[7:0] !== exp) begin
            report_mismatch(what, exp, v[7:0]);
        end
    endtask

    task automatic reset_values();
        spi_pkg::spie_t ie;
        logic [31:0]    v;
        cur_test = "reset_values";
        ie     = '0;
        ie.tne = 1'b1;
        ie.txe = 1'b1;
        read_reg(`SPI_ADDR_SPMODE, v);
        if (v !== `SPI_SPMODE_DEF) begin
            report_mismatch("SPMODE", `SPI_SPMODE_DEF, v);
        end
        read_reg(`SPI_ADDR_SPIE, v);
        if (v !== ie) begin
            report_mismatch("SPIE", ie, v);
        end
        read_reg(`SPI_ADDR_SPIM, v);
        if (v !== `SPI_SPIM_DEF) begin
            report_mismatch("SPIM", `SPI_SPIM_DEF, v);
        end
        read_reg(`SPI_ADDR_SPCOM, v);
        if (v !== `SPI_SPCOM_DEF) begin
            report_mismatch("SPCOM", `SPI_SPCOM_DEF, v);
        end
        for (int k = 0; k < `SPI_NCS; k++) begin
            read_reg(`SPI_ADDR_CSMODE0 + 8'(4 * k), v);
            if (v !== `SPI_CSMODE_DEF) begin
                report_mismatch("CSMODE", `SPI_CSMODE_DEF, v);
            end
        end
        @(negedge S_SYSCLK);
        if (sel !== '1) begin
            report_mismatch("select lines", {`SPI_NCS{1'b1}}, sel);
        end
        if (irq !== 1'b0) begin
            report_mismatch("interrupt", 0, irq);
        end
        if (sck !== 1'b0 || mosi !== 1'b0) begin
            report_mismatch("SCK and MOSI", 0, {sck, mosi});
        end
    endtask

    task automatic loopback_mode0();
        logic [7:0]     sent [3];
        logic [31:0]    v;
        spi_pkg::spie_t ie;
        cur_test = "loopback_mode0";
        write_reg(`SPI_ADDR_CSMODE0, `SPI_CSMODE_DEF);
        set_mode(1'b1, 1'b1);
        for (int i = 0; i < 3; i++) begin
            sent[i] = 8'($random(seed));
            push_byte(sent[i]);
        end
        start_frame(2'd0, 16'd2);
        wait_done();
        for (int i = 0; i < 3; i++) begin
            check_rx(sent[i], "looped byte");
        end
        read_reg(`SPI_ADDR_SPIE, v);
        ie = v;
        if (ie.rne !== 1'b0 || ie.txe !== 1'b1) begin
            report_mismatch("SPIE rne and txe", 2'b01, {ie.rne, ie.txe});
        end
        clear_done();
    endtask

    task automatic slave_modes();
        spi_pkg::csmode_t cm;
        logic [7:0]       sent [2];
        logic [7:0]       reply [2];
        cur_test = "slave_modes";
        set_mode(1'b1, 1'b0);
        for (int m = 0; m < 4; m++) begin
            cm       = '0;
            cm.pol   = 1'b1;
            cm.cpol  = m[1];
            cm.cpha  = m[0];
            cm.pm    = 8'(m + 1);
            cm.csbef = 4'(m + 1);
            cm.csaft = 4'd2;
            write_reg(`SPI_ADDR_CSMODE0 + 8'(4 * m), cm);
            slave_cpol = m[1];
            slave_cpha = m[0];
            slave_out_q.delete();
            slave_seen_q.delete();
            for (int i = 0; i < 2; i++) begin
                sent[i]  = 8'($random(seed));
                reply[i] = 8'($random(seed));
                slave_out_q.push_back(reply[i]);
                push_byte(sent[i]);
            end
            slave_en = 1'b1;
            start_frame(2'(m), 16'd1);
            mon_cpol    = m[1];
            mon_sel_exp = ~(`SPI_NCS'(1) << m);
            mon_seen    = 1'b0;
            mon_en      = 1'b1;
            wait_done();
            mon_en   = 1'b0;
            slave_en = 1'b0;
            if (!mon_seen) begin
                report_problem("no select line was asserted during the frame");
            end
            // 8 bits, two edges each, per character
            if (slave_edges != 32) begin
                report_mismatch("SCK edge count", 32, slave_edges);
            end
            if (slave_seen_q.size() != 2) begin
                report_mismatch("bytes seen by slave", 2, slave_seen_q.size());
            end else begin
                for (int i = 0; i < 2; i++) begin
                    if (slave_seen_q[i] !== sent[i]) begin
                        report_mismatch("MOSI byte", sent[i], slave_seen_q[i]);
                    end
                end
            end
            for (int i = 0; i < 2; i++) begin
                check_rx(reply[i], "MISO byte");
            end
            clear_done();
        end
    endtask

    task automatic tx_stall();
        logic [7:0]     sent [2];
        logic [31:0]    v;
        spi_pkg::spie_t ie;
        cur_test = "tx_stall";
        set_mode(1'b1, 1'b1);
        write_reg(`SPI_ADDR_CSMODE0, `SPI_CSMODE_DEF);
        sent[0] = 8'($random(seed));
        sent[1] = 8'($random(seed));
        push_byte(sent[0]);
        start_frame(2'd0, 16'd1);
        repeat (STALL_CLKS) @(posedge S_SYSCLK);
        read_reg(`SPI_ADDR_SPIE, v);
        ie = v;
        if (ie.don !== 1'b0) begin
            report_mismatch("don while stalled", 0, ie.don);
        end
        @(negedge S_SYSCLK);
        if (sel[0] !== 1'b0) begin
            report_mismatch("select 0 while stalled", 0, sel[0]);
        end
        push_byte(sent[1]);
        wait_done();
        check_rx(sent[0], "first byte");
        check_rx(sent[1], "second byte");
        clear_done();
    endtask

    task automatic done_interrupt();
        spi_pkg::spie_t ie;
        logic [7:0]     b;
        logic [31:0]    v;
        cur_test = "done_interrupt";
        set_mode(1'b1, 1'b1);
        ie     = '0;
        ie.don = 1'b1;
        write_reg(`SPI_ADDR_SPIM, ie);
        b = 8'($random(seed));
        push_byte(b);
        start_frame(2'd0, 16'd0);
        wait_done();
        @(negedge S_SYSCLK);
        if (irq !== 1'b1) begin
            report_mismatch("interrupt after done", 1, irq);
        end
        clear_done();
        read_reg(`SPI_ADDR_SPIE, v);
        ie = v;
        if (ie.don !== 1'b0) begin
            report_mismatch("don after clear", 0, ie.don);
        end
        if (irq !== 1'b0) begin
            report_mismatch("interrupt after clear", 0, irq);
        end
        check_rx(b, "looped byte");
        write_reg(`SPI_ADDR_SPIM, 32'h0);
    endtask

    task automatic start_gating();
        spi_pkg::spcom_t sc;
        spi_pkg::spie_t  ie;
        logic [7:0]      sent [2];
        logic [31:0]     v;
        logic            active;
        cur_test = "start_gating";
        set_mode(1'b0, 1'b0);
        start_frame(2'd1, 16'd0);
        active = 1'b0;
        repeat (64) begin
            @(negedge S_SYSCLK);
            if (sel !== '1) begin
                active = 1'b1;
            end
        end
        if (active) begin
            report_problem("a select line went active with the controller disabled");
        end
        read_reg(`SPI_ADDR_SPIE, v);
        ie = v;
        if (ie.don !== 1'b0) begin
            report_mismatch("don while disabled", 0, ie.don);
        end
        // second command lands in the middle of a running frame
        set_mode(1'b1, 1'b1);
        sent[0] = 8'($random(seed));
        sent[1] = 8'($random(seed));
        push_byte(sent[0]);
        push_byte(sent[1]);
        start_frame(2'd0, 16'd1);
        wait_select(0);
        start_frame(2'd2, 16'd5);
        sc         = '0;
        sc.tranlen = 16'd1;
        read_reg(`SPI_ADDR_SPCOM, v);
        if (v !== sc) begin
            report_mismatch("SPCOM during frame", sc, v);
        end
        wait_done();
        check_rx(sent[0], "first byte");
        check_rx(sent[1], "second byte");
        clear_done();
    endtask

    initial begin
        #(WATCHDOG_CLKS * 2 * CLK_HALF);
        $display("watchdog expired after %0d clocks, the tests did not complete",
                 WATCHDOG_CLKS);
        $display("errors: %0d", errors);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        S_RESETN    = 1'b0;
        reg_wr      = '0;
        araddr      = '0;
        rden        = 1'b0;
        miso        = 1'b0;
        errors      = 0;
        cur_test    = "reset";
        slave_en    = 1'b0;
        slave_cpol  = 1'b0;
        slave_cpha  = 1'b0;
        slave_bits  = 0;
        slave_edges = 0;
        mon_en      = 1'b0;
        mon_cpol    = 1'b0;
        mon_seen    = 1'b0;
        mon_sel_exp = '1;
        repeat (RESET_CYCLES) @(posedge S_SYSCLK);
        S_RESETN <= 1'b1;
        @(posedge S_SYSCLK);
        reset_values();
        loopback_mode0();
        slave_modes();
        tx_stall();
        done_interrupt();
        start_gating();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_master_top.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "spi_params.svh"

module spi_master_top (
    input  wire                     S_SYSCLK,
    input  wire                     S_RESETN,
    input  spi_pkg::reg_wr_t        i_reg_wr,
    input  wire [7:0]               i_araddr,
    input  wire                     i_reg_rden,
    input  wire                     i_spi_miso,
    output wire [31:0]              o_rdata,
    output wire                     o_interrupt,
    output wire                     o_spi_sck,
    output wire                     o_spi_mosi,
    output wire [`SPI_NCS-1:0]      o_spi_sel
);

    spi_pkg::spmode_t spmode;
    spi_pkg::csmode_t csmode;
    spi_pkg::spcom_t  spcom;
    wire        busy;
    wire        frame_start;
    wire        frame_done;
    wire        tx_push;
    wire [7:0]  tx_data;
    wire        tx_pop;
    wire [7:0]  tx_dout;
    wire        tx_empty;
    wire        tx_full;
    wire        rx_push;
    wire [7:0]  rx_din;
    wire        rx_pop;
    wire [7:0]  rx_dout;
    wire        rx_empty;
    wire        rx_full;
    wire        brg_sck;
    wire        lead_edge;
    wire        trail_edge;

    spi_regs u_regs (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_reg_wr(i_reg_wr), .i_araddr(i_araddr), .i_reg_rden(i_reg_rden),
        .i_busy(busy), .i_frame_done(frame_done),
        .i_tx_empty(tx_empty), .i_tx_full(tx_full),
        .i_rx_empty(rx_empty), .i_rx_full(rx_full), .i_rx_data(rx_dout),
        .o_rdata(o_rdata), .o_interrupt(o_interrupt),
        .o_spmode(spmode), .o_csmode(csmode), .o_spcom(spcom),
        .o_frame_start(frame_start), .o_tx_push(tx_push), .o_tx_data(tx_data),
        .o_rx_pop(rx_pop)
    );

    spi_frame_ctrl u_frame (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_spmode(spmode), .i_csmode(csmode), .i_spcom(spcom),
        .i_frame_start(frame_start), .i_lead_edge(lead_edge), .i_trail_edge(trail_edge),
        .i_brg_sck(brg_sck), .i_tx_empty(tx_empty), .i_tx_data(tx_dout),
        .i_spi_miso(i_spi_miso),
        .o_busy(busy), .o_frame_done(frame_done), .o_tx_pop(tx_pop),
        .o_rx_push(rx_push), .o_rx_data(rx_din),
        .o_spi_sck(o_spi_sck), .o_spi_mosi(o_spi_mosi), .o_spi_sel(o_spi_sel)
    );

    // SCK generator runs for the whole frame
    spi_brg u_brg (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_run(busy), .i_cpol(csmode.cpol), .i_pm(csmode.pm),
        .o_sck(brg_sck), .o_lead_edge(lead_edge), .o_trail_edge(trail_edge)
    );

    spi_byte_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_tx_fifo (
        .i_clk(S_SYSCLK), .i_rst_n(S_RESETN),
        .i_push(tx_push), .i_din(tx_data), .i_pop(tx_pop),
        .o_dout(tx_dout), .o_empty(tx_empty), .o_full(tx_full)
    );

    spi_byte_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_rx_fifo (
        .i_clk(S_SYSCLK), .i_rst_n(S_RESETN),
        .i_push(rx_push), .i_din(rx_din), .i_pop(rx_pop),
        .o_dout(rx_dout), .o_empty(rx_empty), .o_full(rx_full)
    );

endmodule

`default_nettype wire

// ==== spi_frame_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "spi_params.svh"

module spi_frame_ctrl (
    input  wire                     S_SYSCLK,
    input  wire                     S_RESETN,
    input  spi_pkg::spmode_t        i_spmode,
    input  spi_pkg::csmode_t        i_csmode,
    input  spi_pkg::spcom_t         i_spcom,
    input  wire                     i_frame_start,
    input  wire                     i_lead_edge,
    input  wire                     i_trail_edge,
    input  wire                     i_brg_sck,
    input  wire                     i_tx_empty,
    input  wire [7:0]               i_tx_data,
    input  wire                     i_spi_miso,
    output wire                     o_busy,
    output logic                    o_frame_done,
    output wire                     o_tx_pop,
    output logic                    o_rx_push,
    output wire [7:0]               o_rx_data,
    output wire                     o_spi_sck,
    output wire                     o_spi_mosi,
    output logic [`SPI_NCS-1:0]     o_spi_sel
);

    spi_pkg::frame_state_e state;
    logic [3:0]  bef_cnt;
    logic [3:0]  aft_cnt;
    logic [15:0] char_cnt;
    logic [3:0]  edge_cnt;
    logic [7:0]  tx_sr;
    logic [7:0]  rx_sr;
    logic        mosi_r;
    logic        din;
    logic        char_end;
    logic        last_char;
    logic        load_char;

    assign din = i_spmode.loop ? mosi_r : i_spi_miso;

    // 16th edge of a character is always a trailing one
    assign char_end  = (state == spi_pkg::IN_TRANS) && i_trail_edge && (edge_cnt == 4'd15);
    assign last_char = (char_cnt == i_spcom.tranlen);
    // new characters start on a trailing edge so SCK sits at idle
    assign load_char = !i_tx_empty && i_trail_edge &&
                       ((state == spi_pkg::DATA_WAIT) || (char_end && !last_char));

    assign o_tx_pop   = load_char;
    assign o_busy     = (state != spi_pkg::IDLE) || i_frame_start;
    assign o_rx_data  = rx_sr;
    assign o_spi_mosi = mosi_r;
    assign o_spi_sck  = (state == spi_pkg::IN_TRANS) ? i_brg_sck : i_csmode.cpol;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state        <= spi_pkg::IDLE;
            bef_cnt      <= '0;
            aft_cnt      <= '0;
            char_cnt     <= '0;
            o_frame_done <= 1'b0;
            o_spi_sel    <= '1;
        end else begin
            o_frame_done <= 1'b0;
            case (state)
                spi_pkg::IDLE: begin
                    if (i_frame_start) begin
                        state                   <= spi_pkg::BEF_WAIT;
                        bef_cnt                 <= i_csmode.csbef;
                        char_cnt                <= '0;
                        o_spi_sel[i_spcom.cs]   <= ~i_csmode.pol;
                    end
                end
                spi_pkg::BEF_WAIT: begin
                    if (bef_cnt == 4'd0) begin
                        state <= spi_pkg::DATA_WAIT;
                    end else if (i_trail_edge) begin
                        bef_cnt <= bef_cnt - 1'b1;
                    end
                end
                spi_pkg::DATA_WAIT: begin
                    if (load_char) begin
                        state <= spi_pkg::IN_TRANS;
                    end
                end
                spi_pkg::IN_TRANS: begin
                    if (char_end) begin
                        char_cnt <= char_cnt + 1'b1;
                        if (last_char) begin
                            state   <= spi_pkg::AFT_WAIT;
                            aft_cnt <= i_csmode.csaft;
                        end else if (!load_char) begin
                            // TX FIFO ran dry
                            state <= spi_pkg::DATA_WAIT;
                        end
                    end
                end
                spi_pkg::AFT_WAIT: begin
                    if (aft_cnt == 4'd0) begin
                        state                 <= spi_pkg::IDLE;
                        o_spi_sel[i_spcom.cs] <= i_csmode.pol;
                        o_frame_done          <= 1'b1;
                    end else if (i_trail_edge) begin
                        aft_cnt <= aft_cnt - 1'b1;
                    end
                end
                default: state <= spi_pkg::IDLE;
            endcase
        end
    end

    // shifter, MSB first
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            edge_cnt  <= '0;
            mosi_r    <= 1'b0;
            o_rx_push <= 1'b0;
        end else begin
            o_rx_push <= char_end;
            // with CPHA 1 the last sample falls on the edge that loads the next character
            if ((state == spi_pkg::IN_TRANS) &&
                ((i_lead_edge && !i_csmode.cpha) || (i_trail_edge && i_csmode.cpha))) begin
                rx_sr <= {rx_sr[6:0], din};
            end
            if (load_char) begin
                edge_cnt <= '0;
                if (i_csmode.cpha) begin
                    // first bit goes out on the leading edge
                    tx_sr <= i_tx_data;
                end else begin
                    mosi_r <= i_tx_data[7];
                    tx_sr  <= {i_tx_data[6:0], 1'b0};
                end
            end else if (state == spi_pkg::IN_TRANS) begin
                if (i_lead_edge || i_trail_edge) begin
                    edge_cnt <= edge_cnt + 1'b1;
                end
                if ((i_trail_edge && !i_csmode.cpha) || (i_lead_edge && i_csmode.cpha)) begin
                    mosi_r <= tx_sr[7];
                    tx_sr  <= {tx_sr[6:0], 1'b0};
                end
            end else if (state == spi_pkg::IDLE) begin
                mosi_r <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_regs.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "spi_params.svh"

module spi_regs (
    input  wire                     S_SYSCLK,
    input  wire                     S_RESETN,
    input  spi_pkg::reg_wr_t        i_reg_wr,
    input  wire [7:0]               i_araddr,
    input  wire                     i_reg_rden,
    input  wire                     i_busy,
    input  wire                     i_frame_done,
    input  wire                     i_tx_empty,
    input  wire                     i_tx_full,
    input  wire                     i_rx_empty,
    input  wire                     i_rx_full,
    input  wire [7:0]               i_rx_data,
    output logic [31:0]             o_rdata,
    output wire                     o_interrupt,
    output spi_pkg::spmode_t        o_spmode,
    output spi_pkg::csmode_t        o_csmode,
    output spi_pkg::spcom_t         o_spcom,
    output logic                    o_frame_start,
    output logic                    o_tx_push,
    output logic [7:0]              o_tx_data,
    output logic                    o_rx_pop
);

    spi_pkg::csmode_t csmode_q [`SPI_NCS];
    logic [31:0]      spim;
    logic             don;
    spi_pkg::spie_t   spie;
    logic             wr_ok;

    // only full 32-bit writes are accepted
    assign wr_ok = i_reg_wr.wen && (i_reg_wr.wstrb == 4'hF);

    always_comb begin
        spie      = '0;
        spie.don  = don;
        spie.rne  = !i_rx_empty;
        spie.rxf  = i_rx_full;
        spie.tne  = !i_tx_full;
        spie.txe  = i_tx_empty;
    end

    assign o_interrupt = |(spim & spie);
    assign o_csmode    = csmode_q[o_spcom.cs];

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            o_spmode      <= `SPI_SPMODE_DEF;
            spim          <= `SPI_SPIM_DEF;
            o_spcom       <= `SPI_SPCOM_DEF;
            don           <= 1'b0;
            o_frame_start <= 1'b0;
            o_tx_push     <= 1'b0;
            o_rx_pop      <= 1'b0;
            for (int k = 0; k < `SPI_NCS; k++) begin
                csmode_q[k] <= `SPI_CSMODE_DEF;
            end
        end else begin
            o_frame_start <= 1'b0;
            o_tx_push     <= 1'b0;
            // pop after the read data has been presented
            o_rx_pop      <= i_reg_rden && (i_araddr == `SPI_ADDR_SPIRF);

            // done event beats a clearing write in the same cycle
            if (i_frame_done) begin
                don <= 1'b1;
            end else if (wr_ok && (i_reg_wr.awaddr == `SPI_ADDR_SPIE) &&
                         i_reg_wr.wdata[0]) begin
                don <= 1'b0;
            end

            if (wr_ok) begin
                case (i_reg_wr.awaddr)
                    `SPI_ADDR_SPMODE: o_spmode <= i_reg_wr.wdata;
                    `SPI_ADDR_SPIM:   spim     <= i_reg_wr.wdata;
                    `SPI_ADDR_SPCOM: begin
                        // locked while a frame runs
                        if (!i_busy) begin
                            o_spcom       <= i_reg_wr.wdata;
                            o_frame_start <= o_spmode.en;
                        end
                    end
                    `SPI_ADDR_SPITF: begin
                        o_tx_push <= o_spmode.en;
                        o_tx_data <= i_reg_wr.wdata[7:0];
                    end
                    default: begin
                        for (int k = 0; k < `SPI_NCS; k++) begin
                            if (i_reg_wr.awaddr == `SPI_ADDR_CSMODE0 + 8'(4 * k)) begin
                                csmode_q[k] <= i_reg_wr.wdata;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        o_rdata = '0;
        case (i_araddr)
            `SPI_ADDR_SPMODE: o_rdata = o_spmode;
            `SPI_ADDR_SPIE:   o_rdata = spie;
            `SPI_ADDR_SPIM:   o_rdata = spim;
            `SPI_ADDR_SPCOM:  o_rdata = o_spcom;
            `SPI_ADDR_SPIRF:  o_rdata = {24'h0, i_rx_data};
            default: begin
                for (int k = 0; k < `SPI_NCS; k++) begin
                    if (i_araddr == `SPI_ADDR_CSMODE0 + 8'(4 * k)) begin
                        o_rdata = csmode_q[k];
                    end
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== spi_brg.sv ====
`default_nettype none
`timescale 1ns/1ns

module spi_brg (
    input  wire        S_SYSCLK,
    input  wire        S_RESETN,
    input  wire        i_run,
    input  wire        i_cpol,
    input  wire [7:0]  i_pm,
    output logic       o_sck,
    output logic       o_lead_edge,
    output logic       o_trail_edge
);

    logic [7:0] cnt;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt          <= '0;
            o_sck        <= 1'b0;
            o_lead_edge  <= 1'b0;
            o_trail_edge <= 1'b0;
        end else begin
            o_lead_edge  <= 1'b0;
            o_trail_edge <= 1'b0;
            if (!i_run) begin
                // park at idle level, ready for a full half period
                cnt   <= i_pm;
                o_sck <= i_cpol;
            end else if (cnt == 8'd0) begin
                cnt   <= i_pm;
                o_sck <= ~o_sck;
                // leaving the idle level is the leading edge
                if (o_sck == i_cpol) begin
                    o_lead_edge <= 1'b1;
                end else begin
                    o_trail_edge <= 1'b1;
                end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_byte_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module spi_byte_fifo #(
    parameter int DEPTH = 16
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_push,
    input  wire [7:0]  i_din,
    input  wire        i_pop,
    output wire [7:0]  o_dout,
    output wire        o_empty,
    output wire        o_full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // full and empty requests are dropped here
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == CW'(DEPTH));
    assign o_dout  = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    // frame machine states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        BEF_WAIT  = 3'd1,
        DATA_WAIT = 3'd2,
        IN_TRANS  = 3'd3,
        AFT_WAIT  = 3'd4
    } frame_state_e;

    // pol = 1 means the select line idles high
    typedef struct packed {
        logic [12:0] rsvd;
        logic [3:0]  csaft;
        logic [3:0]  csbef;
        logic [7:0]  pm;
        logic        cpha;
        logic        cpol;
        logic        pol;
    } csmode_t;

    // tranlen is characters minus one
    typedef struct packed {
        logic [1:0]  cs;
        logic [13:0] rsvd;
        logic [15:0] tranlen;
    } spcom_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        loop;
        logic        en;
    } spmode_t;

    // don is sticky, the rest follow the FIFO flags
    typedef struct packed {
        logic [26:0] rsvd;
        logic        txe;
        logic        tne;
        logic        rxf;
        logic        rne;
        logic        don;
    } spie_t;

    typedef struct packed {
        logic        wen;
        logic [7:0]  awaddr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } reg_wr_t;

endpackage

`default_nettype wire

// ==== spi_params.svh ====
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// chip selects and FIFO size
`define SPI_NCS             4
`define SPI_FIFO_DEPTH      16

// register map, byte addresses on the 8-bit bus
`define SPI_ADDR_SPMODE     8'h00
`define SPI_ADDR_SPIE       8'h04
`define SPI_ADDR_SPIM       8'h08
`define SPI_ADDR_SPCOM      8'h0C
`define SPI_ADDR_SPITF      8'h10
`define SPI_ADDR_SPIRF      8'h14
// CSMODE0..CSMODE3 follow as consecutive words
`define SPI_ADDR_CSMODE0    8'h20

// reset values
`define SPI_SPMODE_DEF      32'h0000_0000
`define SPI_SPIM_DEF        32'h0000_0000
`define SPI_SPCOM_DEF       32'h0000_0000
// active-low select, mode 0, pm 0, no delays
`define SPI_CSMODE_DEF      32'h0000_0001

`endif
